// ==== kcpu_top.f ====
+incdir+include
hdl/kcpu_pkg.sv
hdl/kcpu_opdecode.sv
hdl/kcpu_ucode.sv
hdl/kcpu_alu.sv
hdl/kcpu_fetch.sv
hdl/kcpu_stack.sv
hdl/kcpu_bus_arbiter.sv
hdl/kcpu_top.sv
testbench/kcpu_asserts.sv
testbench/kcpu_tb.sv

// ==== Makefile ====
TOP = kcpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f kcpu_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f kcpu_top.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// ==== testbench/kcpu_tb.sv ====
// kcpu testbench
// random program in a 256-byte memory, random cen and irq,
// instruction level model checked at each sync, write and irq_ack
`include "kcpu_defs.svh"

module kcpu_tb import kcpu_pkg::*; ();

logic  clk = 1'b0;
logic  rst;
logic  cen;
logic  irq;
byte_t bus_rdata;
addr_t bus_addr;
byte_t bus_wdata;
logic  bus_rd, bus_we, sync, irq_ack, halted;

integer seed = 32'h6bb7;
byte_t  mem [256];      // memory seen by the dut
byte_t  m_mem [256];    // model copy
addr_t  gen_a;          // program build pointer
int     n_instr;

// model state
byte_t  m_acc;
logic   m_zero, m_int_en, m_halt;
addr_t  m_pc, m_sp;
addr_t  exp_wa [$];     // expected bus writes, in order
byte_t  exp_wd [$];

int     err_value, err_other;
logic   halted_seen;
longint limit;

kcpu_top uut (
    .clk       (clk),
    .rst       (rst),
    .cen       (cen),
    .irq       (irq),
    .bus_rdata (bus_rdata),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rd    (bus_rd),
    .bus_we    (bus_we),
    .sync      (sync),
    .irq_ack   (irq_ack),
    .halted    (halted)
);

always #50 clk = ~clk;

// memory with read data held until the next read
always @(posedge clk) begin
    if (bus_rd) bus_rdata <= mem[bus_addr];
    if (bus_we) mem[bus_addr] <= bus_wdata;
end

// cen about 80 percent high
always @(posedge clk) begin
    cen <= ({$random(seed)} % 10) < 8;
end

// irq raised at random and held until acknowledged
always @(posedge clk) begin
    if (rst)                                  irq <= 1'b0;
    else if (irq && irq_ack)                  irq <= 1'b0;
    else if (!irq && ({$random(seed)} % 48) == 0) irq <= 1'b1;
end

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
        err_value++;
        $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        err_value++;
        $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        err_value++;
        $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
    end
endtask

task automatic put_byte(input byte_t b);
    mem[gen_a] = b;
    gen_a++;
endtask

// opcode and its operand byte
task automatic put_pair(input byte_t opc, input byte_t opd);
    put_byte(opc);
    put_byte(opd);
endtask

// forward-only branches, stores into a0..bf, undefined opcode run at the end
task automatic build_program();
    int pick;
    for (int i = 0; i < 256; i++) mem[i] = byte_t'($random(seed));
    gen_a   = 8'h00;
    n_instr = 0;
    while (gen_a < 8'h78) begin
        pick = {$random(seed)} % 14;
        n_instr++;
        case (pick)
            0:       put_byte(`KCPU_OP_NOP);
            1, 2:    put_pair(`KCPU_OP_LDA, byte_t'($random(seed)));
            3:       put_pair(`KCPU_OP_ADDA, byte_t'($random(seed)));
            4:       put_pair(`KCPU_OP_ANDA, byte_t'($random(seed)));
            5:       put_pair(`KCPU_OP_EORA, byte_t'($random(seed)));
            6, 7:    put_pair(`KCPU_OP_STA, 8'ha0 + byte_t'({$random(seed)} % 32));
            8:       put_byte(`KCPU_OP_PSHA);
            9:       put_byte(`KCPU_OP_PULA);
            10:      put_pair(`KCPU_OP_BRA, byte_t'({$random(seed)} % 4));
            11:      put_pair(`KCPU_OP_BEQ, byte_t'({$random(seed)} % 4));
            default: put_byte(`KCPU_OP_CLI);
        endcase
    end
    for (int i = 0; i < 8; i++) put_byte(8'hff);  // wider than any branch skip
    // irq handler
    gen_a = `KCPU_IRQ_VEC;
    put_byte(`KCPU_OP_LDA);
    put_byte(byte_t'($random(seed)));
    put_byte(`KCPU_OP_ADDA);
    put_byte(byte_t'($random(seed)));
    put_byte(`KCPU_OP_RTI);
    for (int i = 0; i < 256; i++) m_mem[i] = mem[i];
endtask

task automatic set_acc(input byte_t v);
    m_acc  = v;
    m_zero = (v == 8'h00);
endtask

task automatic model_write(input addr_t a, input byte_t d);
    exp_wa.push_back(a);
    exp_wd.push_back(d);
    m_mem[a] = d;
endtask

// operand byte follows these opcodes
function automatic logic takes_operand(input byte_t opc);
    case (opc)
        `KCPU_OP_LDA, `KCPU_OP_ADDA, `KCPU_OP_ANDA, `KCPU_OP_EORA,
        `KCPU_OP_STA, `KCPU_OP_BRA, `KCPU_OP_BEQ: takes_operand = 1'b1;
        default:                                  takes_operand = 1'b0;
    endcase
endfunction

// relative target, offset taken as a signed byte
function automatic addr_t branch_dest(input addr_t base, input byte_t off);
    int off_s;
    off_s       = int'(signed'(off));
    branch_dest = addr_t'(int'(base) + off_s);
endfunction

// one whole instruction per sync
task automatic step_instr();
    byte_t opc;
    byte_t opd;
    check_addr("bus_addr at sync", bus_addr, m_pc);
    check_flag("irq pending and enabled at sync", irq & m_int_en, 1'b0);
    opc = m_mem[m_pc];
    m_pc++;
    opd = m_mem[m_pc];          // operand byte, if the opcode has one
    if (takes_operand(opc)) m_pc++;
    case (opc)
        `KCPU_OP_NOP: ;
        `KCPU_OP_LDA:  set_acc(opd);
        `KCPU_OP_ADDA: set_acc(m_acc + opd);
        `KCPU_OP_ANDA: set_acc(m_acc & opd);
        `KCPU_OP_EORA: set_acc(m_acc ^ opd);
        `KCPU_OP_STA:  model_write(opd, m_acc);
        `KCPU_OP_PSHA: begin
            m_sp--;
            model_write(m_sp, m_acc);
        end
        `KCPU_OP_PULA: begin
            set_acc(m_mem[m_sp]);
            m_sp++;
        end
        `KCPU_OP_BRA:  m_pc = branch_dest(m_pc, opd);
        `KCPU_OP_BEQ:  if (m_zero) m_pc = branch_dest(m_pc, opd);
        `KCPU_OP_CLI:  m_int_en = 1'b1;
        `KCPU_OP_RTI: begin
            m_pc = m_mem[m_sp];
            m_sp++;
            m_int_en = 1'b1;
        end
        default:       m_halt = 1'b1;  // undefined
    endcase
endtask

task automatic irq_entry();
    check_flag("irq at irq_ack", irq, 1'b1);
    check_flag("model int_en at irq_ack", m_int_en, 1'b1);
    m_sp--;
    model_write(m_sp, m_pc);    // return pc
    m_pc     = `KCPU_IRQ_VEC;
    m_int_en = 1'b0;
endtask

task automatic check_write();
    if (exp_wa.size() == 0) begin
        err_other++;
        $display("bus write at %0t that the model did not expect", $time);
    end else begin
        check_addr("bus_addr on write", bus_addr, exp_wa.pop_front());
        check_byte("bus_wdata", bus_wdata, exp_wd.pop_front());
    end
endtask

// sampled mid cycle away from the edge
always @(negedge clk) begin
    if (!rst) begin
        if (halted_seen) begin
            if (sync || bus_rd || bus_we) begin
                err_other++;
                $display("bus activity at %0t after the core halted", $time);
            end
        end else begin
            if (bus_we) check_write();
            if (irq_ack) irq_entry();
            if (sync) step_instr();
            if (halted) begin
                if (!m_halt) begin
                    err_other++;
                    $display("core halted at %0t on a defined opcode", $time);
                end
                halted_seen = 1'b1;
            end
        end
    end
end

initial begin
    rst         = 1'b1;
    cen         = 1'b0;
    irq         = 1'b0;
    bus_rdata   = 8'h00;
    err_value   = 0;
    err_other   = 0;
    halted_seen = 1'b0;
    m_acc       = 8'h00;
    m_zero      = 1'b0;
    m_int_en    = 1'b0;
    m_halt      = 1'b0;
    m_pc        = `KCPU_RESET_PC;
    m_sp        = `KCPU_RESET_SP;
    build_program();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait (halted_seen);
    repeat (30) @(negedge clk);  // quiet bus after halt
    check_flag("halted", halted, 1'b1);
    if (exp_wa.size() != 0) begin
        err_other++;
        $display("%0d expected bus writes never happened", exp_wa.size());
    end
    err_other += uut.u_asserts.n_fail;  // failed bound assertions
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

// irqs add handler instructions, cen low stretches each step
initial begin
    #1;
    limit = longint'(n_instr * 4 + 64) * 6 * 4 * 100;
    #(limit);
    $display("timeout: core did not halt within %0d time units", limit);
    $display("Regression failed");
    $finish;
end

endmodule

// ==== testbench/kcpu_asserts.sv ====
// kcpu bus and strobe assertions
// bound into kcpu_top
module kcpu_asserts (
    input logic clk,
    input logic rst,
    input logic bus_rd,
    input logic bus_we,
    input logic sync,
    input logic irq_ack,
    input logic int_en,
    input logic halted,
    input logic push,
    input logic pull,
    input logic store,
    input logic alu_go
);

int n_fail = 0;  // failed assertion count

// one bus direction at a time
a_rd_we: assert property (@(posedge clk) disable iff (rst) !(bus_rd && bus_we))
    else begin
        $error("bus_rd and bus_we high together");
        n_fail++;
    end

// irq entry replaces the opcode fetch
a_ack_sync: assert property (@(posedge clk) disable iff (rst) !(irq_ack && sync))
    else begin
        $error("irq_ack together with sync");
        n_fail++;
    end

// irq entry only while interrupts are enabled
a_ack_en: assert property (@(posedge clk) disable iff (rst) irq_ack |-> int_en)
    else begin
        $error("irq_ack with int_en low");
        n_fail++;
    end

// only reset leaves the halt
a_halt: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else begin
        $error("halted dropped without reset");
        n_fail++;
    end

// opcode fetch is the only legal activity right out of reset
a_quiet: assert property (@(posedge clk)
    $past(rst) |-> !(bus_we || irq_ack || halted || push || pull || store || alu_go))
    else begin
        $error("strobe active in the cycle after reset");
        n_fail++;
    end

endmodule

bind kcpu_top kcpu_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .bus_rd  (bus_rd),
    .bus_we  (bus_we),
    .sync    (sync),
    .irq_ack (irq_ack),
    .int_en  (int_en),
    .halted  (halted),
    .push    (push),
    .pull    (pull),
    .store   (store),
    .alu_go  (alu_go)
);

// ==== hdl/kcpu_top.sv ====
// kcpu top level
// decoder, sequencer, fetch, stack and alu on one arbitrated memory bus
module kcpu_top import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  irq,
    input  byte_t bus_rdata,
    output addr_t bus_addr,
    output byte_t bus_wdata,
    output logic  bus_rd,
    output logic  bus_we,
    output logic  sync,
    output logic  irq_ack,
    output logic  halted
);

opcat_t opcat;
byte_t  op, arg, acc, pull_data, push_data, stack_wdata;
addr_t  pc, fetch_addr, stack_addr;
logic   zero, int_en, bus_stall;
logic   fetch_op, fetch_arg, take_branch, load_pc, vec;
logic   push, push_pc, pull, store, alu_go, pul_to_acc;
logic   fetch_req, fetch_gnt, stack_req, stack_we, stack_gnt;

assign push_data = push_pc ? pc : acc;  // return pc on irq entry

kcpu_opdecode u_opdecode (
    .op    (op),
    .opcat (opcat)
);

kcpu_ucode u_ucode (
    .clk         (clk),
    .rst         (rst),
    .cen         (cen),
    .opcat       (opcat),
    .op          (op),
    .zero        (zero),
    .irq         (irq),
    .bus_stall   (bus_stall),
    .fetch_op    (fetch_op),
    .fetch_arg   (fetch_arg),
    .take_branch (take_branch),
    .load_pc     (load_pc),
    .vec         (vec),
    .push        (push),
    .push_pc     (push_pc),
    .pull        (pull),
    .store       (store),
    .alu_go      (alu_go),
    .pul_to_acc  (pul_to_acc),
    .int_en      (int_en),
    .irq_ack     (irq_ack),
    .halted      (halted)
);

kcpu_alu u_alu (
    .clk        (clk),
    .rst        (rst),
    .cen        (cen),
    .alu_go     (alu_go),
    .pul_to_acc (pul_to_acc),
    .op         (op),
    .arg        (arg),
    .pull_data  (pull_data),
    .acc        (acc),
    .zero       (zero)
);

kcpu_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .cen         (cen),
    .fetch_op    (fetch_op),
    .fetch_arg   (fetch_arg),
    .take_branch (take_branch),
    .load_pc     (load_pc),
    .vec         (vec),
    .gnt         (fetch_gnt),
    .rdata       (bus_rdata),
    .pull_data   (pull_data),
    .req         (fetch_req),
    .addr        (fetch_addr),
    .op          (op),
    .arg         (arg),
    .pc          (pc),
    .sync        (sync)
);

kcpu_stack u_stack (
    .clk        (clk),
    .rst        (rst),
    .cen        (cen),
    .push       (push),
    .pull       (pull),
    .store      (store),
    .gnt        (stack_gnt),
    .push_data  (push_data),
    .rdata      (bus_rdata),
    .store_addr (arg),        // sta direct address
    .req        (stack_req),
    .we         (stack_we),
    .addr       (stack_addr),
    .wdata      (stack_wdata),
    .pull_data  (pull_data)
);

kcpu_bus_arbiter u_arbiter (
    .clk         (clk),
    .rst         (rst),
    .cen         (cen),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .stack_req   (stack_req),
    .stack_we    (stack_we),
    .stack_addr  (stack_addr),
    .stack_wdata (stack_wdata),
    .fetch_gnt   (fetch_gnt),
    .stack_gnt   (stack_gnt),
    .bus_stall   (bus_stall),
    .bus_rd      (bus_rd),
    .bus_we      (bus_we),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata)
);

endmodule

// ==== hdl/kcpu_bus_arbiter.sv ====
// kcpu memory bus arbiter
// stack over fetch, fixed priority; tracks who owns the read in flight
module kcpu_bus_arbiter import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    input  logic  stack_req,
    input  logic  stack_we,
    input  addr_t stack_addr,
    input  byte_t stack_wdata,
    output logic  fetch_gnt,
    output logic  stack_gnt,
    output logic  bus_stall,
    output logic  bus_rd,
    output logic  bus_we,
    output addr_t bus_addr,
    output byte_t bus_wdata
);

logic fetch_win;   // fetch owns the bus this cycle
logic rd_fetch;    // read data due to fetch
logic rd_stack;    // read data due to stack

assign fetch_win = fetch_req & ~stack_req;
assign bus_stall = fetch_req & stack_req;   // fetch loses, sequencer waits

// gnt doubles as the data return flag for the read owner
assign fetch_gnt = cen & (fetch_win | rd_fetch);
assign stack_gnt = cen & (stack_req | rd_stack);

assign bus_rd    = cen & (fetch_win | (stack_req & ~stack_we));
assign bus_we    = cen & stack_req & stack_we;
assign bus_addr  = stack_req ? stack_addr : fetch_addr;
assign bus_wdata = stack_wdata;             // only the stack writes

always_ff @(posedge clk) begin
    if (rst) begin
        rd_fetch <= 1'b0;
        rd_stack <= 1'b0;
    end else if (cen) begin
        rd_fetch <= fetch_win;
        rd_stack <= stack_req & ~stack_we;
    end
end

endmodule

// ==== hdl/kcpu_stack.sv ====
// kcpu stack unit
// stack pointer with push and pull accesses, also carries the sta write
`include "kcpu_defs.svh"

module kcpu_stack import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  push,
    input  logic  pull,
    input  logic  store,
    input  logic  gnt,
    input  byte_t push_data,
    input  byte_t rdata,
    input  addr_t store_addr,
    output logic  req,
    output logic  we,
    output addr_t addr,
    output byte_t wdata,
    output byte_t pull_data
);

addr_t sp;

assign req   = push | pull | store;
assign we    = push | store;        // pull is the only read
assign wdata = push_data;           // acc or pc, picked at the top

// pre-decrement for push, sp as is for pull
always_comb begin
    if (store)     addr = store_addr;
    else if (push) addr = sp - addr_t'(1);
    else           addr = sp;
end

always_ff @(posedge clk) begin
    if (rst) begin
        sp <= `KCPU_RESET_SP;
    end else if (cen && req && gnt) begin
        if (push)      sp <= sp - addr_t'(1);
        else if (pull) sp <= sp + addr_t'(1);  // post-increment
    end
end

// pulled byte held for the alu and the fetch unit
always_ff @(posedge clk) begin
    if (cen && gnt && !req) pull_data <= rdata;
end

endmodule

// ==== hdl/kcpu_fetch.sv ====
// kcpu fetch unit
// program counter, opcode and operand reads, branch and vector loads
`include "kcpu_defs.svh"

module kcpu_fetch import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  fetch_op,
    input  logic  fetch_arg,
    input  logic  take_branch,
    input  logic  load_pc,
    input  logic  vec,
    input  logic  gnt,
    input  byte_t rdata,
    input  byte_t pull_data,
    output logic  req,
    output addr_t addr,
    output byte_t op,
    output byte_t arg,
    output addr_t pc,
    output logic  sync
);

addr_t br_target;
logic  pend_arg;  // kind of the read in flight
logic  ret;       // read data for us on the bus

assign req  = fetch_op | fetch_arg;
assign addr = pc;                 // reads always at pc
assign sync = fetch_op & gnt;     // instruction start marker
assign ret  = gnt & ~req;         // gnt without req is the data return

// pc already points past the offset byte, 8-bit wrap gives the signed add
assign br_target = pc + arg;

always_ff @(posedge clk) begin
    if (rst) begin
        pc       <= `KCPU_RESET_PC;
        pend_arg <= 1'b0;
    end else if (cen) begin
        if (req && gnt) pend_arg <= fetch_arg;
        if (vec) begin
            pc <= `KCPU_IRQ_VEC;
        end else if (load_pc) begin
            pc <= pull_data;      // rti
        end else if (take_branch) begin
            pc <= br_target;
        end else if (req && gnt) begin
            pc <= pc + addr_t'(1);
        end
    end
end

// payload capture, one cen cycle after the read
always_ff @(posedge clk) begin
    if (cen && ret) begin
        if (pend_arg) arg <= rdata;
        else          op  <= rdata;
    end
end

endmodule

// ==== hdl/kcpu_alu.sv ====
// kcpu accumulator alu
// load, add, and, exclusive-or on the immediate operand, plus pulled loads
`include "kcpu_defs.svh"

module kcpu_alu import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  alu_go,
    input  logic  pul_to_acc,
    input  byte_t op,
    input  byte_t arg,
    input  byte_t pull_data,
    output byte_t acc,
    output logic  zero
);

byte_t res;  // next acc for alu_go

always_comb begin
    case (op)
        `KCPU_OP_LDA:  res = arg;
        `KCPU_OP_ADDA: res = acc + arg;  // carry dropped
        `KCPU_OP_ANDA: res = acc & arg;
        `KCPU_OP_EORA: res = acc ^ arg;
        default:       res = acc;
    endcase
end

// zero follows every acc write
always_ff @(posedge clk) begin
    if (rst) begin
        acc  <= '0;
        zero <= 1'b0;
    end else if (cen) begin
        if (pul_to_acc) begin
            acc  <= pull_data;
            zero <= (pull_data == '0);
        end else if (alu_go) begin
            acc  <= res;
            zero <= (res == '0);
        end
    end
end

endmodule

// ==== hdl/kcpu_ucode.sv ====
// kcpu microcode sequencer
// steps through the routine of the current category, drives the unit strobes,
// dispatches on ni with irq entry, halts on bus error
`include "kcpu_defs.svh"

module kcpu_ucode import kcpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    input  opcat_t opcat,
    input  byte_t  op,
    input  logic   zero,
    input  logic   irq,
    input  logic   bus_stall,
    output logic   fetch_op,
    output logic   fetch_arg,
    output logic   take_branch,
    output logic   load_pc,
    output logic   vec,
    output logic   push,
    output logic   push_pc,
    output logic   pull,
    output logic   store,      // acc to the direct address in arg
    output logic   alu_go,
    output logic   pul_to_acc,
    output logic   int_en,
    output logic   irq_ack,
    output logic   halted
);

uaddr_t      ua;        // current microcode row
logic [13:0] row;
logic        r_ni, r_fop, r_farg, r_br, r_ldpc, r_vec, r_push;
logic        r_ppc, r_pull, r_st, r_alu, r_pacc, r_sie, r_berr;
logic        irq_go;    // irq would be taken now
logic        irq_take;  // irq decided at the opcode fetch step
logic        br_cond;
logic        adv;       // sequencer moves this cycle

// first row of a category routine
function automatic uaddr_t entry(input opcat_t c);
    entry = uaddr_t'(c) * uaddr_t'(`KCPU_UROWS);
endfunction

// row columns
// ni fop farg br | ldpc vec push ppc | pull st alu pacc | sie berr
// every routine ends with: fop, wait for the opcode, ni
always_comb begin
    case (ua)
        {cat_reset, 4'd0}:    row = 14'b0100_0000_0000_00;
        {cat_reset, 4'd1}:    row = 14'b0000_0000_0000_00;  // opcode returns
        {cat_reset, 4'd2}:    row = 14'b1000_0000_0000_00;

        {cat_alu_imm, 4'd0}:  row = 14'b0010_0000_0000_00;  // operand read
        {cat_alu_imm, 4'd1}:  row = 14'b0000_0000_0000_00;
        {cat_alu_imm, 4'd2}:  row = 14'b0100_0000_0010_00;  // alu with next fetch
        {cat_alu_imm, 4'd3}:  row = 14'b0000_0000_0000_00;
        {cat_alu_imm, 4'd4}:  row = 14'b1000_0000_0000_00;

        {cat_store, 4'd0}:    row = 14'b0010_0000_0000_00;  // address byte
        {cat_store, 4'd1}:    row = 14'b0000_0000_0000_00;
        {cat_store, 4'd2}:    row = 14'b0000_0000_0100_00;  // write acc
        {cat_store, 4'd3}:    row = 14'b0100_0000_0000_00;
        {cat_store, 4'd4}:    row = 14'b0000_0000_0000_00;
        {cat_store, 4'd5}:    row = 14'b1000_0000_0000_00;

        {cat_psh, 4'd0}:      row = 14'b0000_0010_0000_00;
        {cat_psh, 4'd1}:      row = 14'b0100_0000_0000_00;
        {cat_psh, 4'd2}:      row = 14'b0000_0000_0000_00;
        {cat_psh, 4'd3}:      row = 14'b1000_0000_0000_00;

        {cat_pul, 4'd0}:      row = 14'b0000_0000_1000_00;
        {cat_pul, 4'd1}:      row = 14'b0000_0000_0000_00;  // stack captures
        {cat_pul, 4'd2}:      row = 14'b0100_0000_0001_00;
        {cat_pul, 4'd3}:      row = 14'b0000_0000_0000_00;
        {cat_pul, 4'd4}:      row = 14'b1000_0000_0000_00;

        {cat_branch, 4'd0}:   row = 14'b0010_0000_0000_00;  // offset byte
        {cat_branch, 4'd1}:   row = 14'b0000_0000_0000_00;
        {cat_branch, 4'd2}:   row = 14'b0001_0000_0000_00;  // conditional add
        {cat_branch, 4'd3}:   row = 14'b0100_0000_0000_00;
        {cat_branch, 4'd4}:   row = 14'b0000_0000_0000_00;
        {cat_branch, 4'd5}:   row = 14'b1000_0000_0000_00;

        // int_en set before the fetch so a waiting irq is seen there
        {cat_cli, 4'd0}:      row = 14'b0000_0000_0000_10;
        {cat_cli, 4'd1}:      row = 14'b0100_0000_0000_00;
        {cat_cli, 4'd2}:      row = 14'b0000_0000_0000_00;
        {cat_cli, 4'd3}:      row = 14'b1000_0000_0000_00;

        {cat_rti, 4'd0}:      row = 14'b0000_0000_1000_00;  // return pc
        {cat_rti, 4'd1}:      row = 14'b0000_0000_0000_00;
        {cat_rti, 4'd2}:      row = 14'b0000_1000_0000_10;
        {cat_rti, 4'd3}:      row = 14'b0100_0000_0000_00;
        {cat_rti, 4'd4}:      row = 14'b0000_0000_0000_00;
        {cat_rti, 4'd5}:      row = 14'b1000_0000_0000_00;

        {cat_nop, 4'd0}:      row = 14'b0100_0000_0000_00;
        {cat_nop, 4'd1}:      row = 14'b0000_0000_0000_00;
        {cat_nop, 4'd2}:      row = 14'b1000_0000_0000_00;

        // push writes the old pc in the same cycle the vector loads
        {cat_irq, 4'd0}:      row = 14'b0000_0111_0000_00;
        {cat_irq, 4'd1}:      row = 14'b0100_0000_0000_00;
        {cat_irq, 4'd2}:      row = 14'b0000_0000_0000_00;
        {cat_irq, 4'd3}:      row = 14'b1000_0000_0000_00;

        {cat_buserror, 4'd0}: row = 14'b0000_0000_0000_01;
        default:              row = 14'b0000_0000_0000_01;  // runaway, halt too
    endcase
end

assign {r_ni, r_fop, r_farg, r_br, r_ldpc, r_vec, r_push,
        r_ppc, r_pull, r_st, r_alu, r_pacc, r_sie, r_berr} = row;

assign adv     = cen & ~bus_stall;
assign irq_go  = irq & int_en;
assign br_cond = (op == `KCPU_OP_BRA) || (op == `KCPU_OP_BEQ && zero);

// bus strobes, held through a stall so the request repeats
assign fetch_op  = cen & r_fop & ~irq_go;   // skip the fetch when irq wins
assign fetch_arg = cen & r_farg;
assign push      = cen & r_push;
assign push_pc   = cen & r_ppc;
assign pull      = cen & r_pull;
assign store     = cen & r_st;

// internal strobes act once per step
assign take_branch = adv & r_br & br_cond;
assign load_pc     = adv & r_ldpc;
assign vec         = adv & r_vec;
assign alu_go      = adv & r_alu;
assign pul_to_acc  = adv & r_pacc;
assign irq_ack     = adv & r_ni & irq_take;

always_ff @(posedge clk) begin
    if (rst) begin
        ua       <= entry(cat_reset);
        int_en   <= 1'b0;
        irq_take <= 1'b0;
        halted   <= 1'b0;
    end else if (adv && !halted) begin
        if (r_berr) begin
            halted <= 1'b1;  // address stays frozen
        end else if (r_ni) begin
            irq_take <= 1'b0;
            if (irq_take) begin
                ua     <= entry(cat_irq);
                int_en <= 1'b0;  // no nesting
            end else begin
                ua <= entry(opcat);
            end
        end else begin
            ua <= ua + uaddr_t'(1);
        end
        if (r_fop) irq_take <= irq_go;  // decision sticks until ni
        if (r_sie) int_en <= 1'b1;
    end
end

endmodule

// ==== hdl/kcpu_opdecode.sv ====
// kcpu opcode decoder
// maps the latched opcode to its microcode routine category
`include "kcpu_defs.svh"

module kcpu_opdecode import kcpu_pkg::*; (
    input  byte_t  op,
    output opcat_t opcat
);

always_comb begin
    case (op)
        `KCPU_OP_LDA,
        `KCPU_OP_ADDA,
        `KCPU_OP_ANDA,
        `KCPU_OP_EORA: opcat = cat_alu_imm;  // alu picks the operation from op

        `KCPU_OP_BRA,
        `KCPU_OP_BEQ:  opcat = cat_branch;   // condition resolved in the sequencer

        `KCPU_OP_STA:  opcat = cat_store;
        `KCPU_OP_PSHA: opcat = cat_psh;
        `KCPU_OP_PULA: opcat = cat_pul;
        `KCPU_OP_CLI:  opcat = cat_cli;
        `KCPU_OP_RTI:  opcat = cat_rti;
        `KCPU_OP_NOP:  opcat = cat_nop;
        default:       opcat = cat_buserror; // stop condition
    endcase
end

endmodule

// ==== hdl/kcpu_pkg.sv ====
// kcpu types
// data, address and microcode address vectors, routine categories
package kcpu_pkg;

typedef logic [7:0] byte_t;     // data byte
typedef logic [7:0] addr_t;     // memory address
typedef logic [7:0] uaddr_t;    // {category, step}

// one 16-row microcode routine per category
// category number is the upper nibble of the microcode address
typedef enum logic [3:0] {
    cat_reset,      // first opcode fetch after reset
    cat_alu_imm,    // lda, adda, anda, eora
    cat_store,      // sta direct
    cat_psh,
    cat_pul,
    cat_branch,     // bra, beq
    cat_cli,
    cat_rti,
    cat_nop,
    cat_irq,        // entered from dispatch, never decoded
    cat_buserror    // undefined opcode, halts
} opcat_t;

endpackage

// ==== include/kcpu_defs.svh ====
// kcpu shared constants
// opcode map, reset and irq vectors, microcode geometry
`ifndef KCPU_DEFS_SVH
`define KCPU_DEFS_SVH

// single byte opcodes
`define KCPU_OP_NOP   8'h12
`define KCPU_OP_CLI   8'h1c    // sets the interrupt enable
`define KCPU_OP_RTI   8'h3b    // pulls pc, sets the interrupt enable

// immediate alu group, operand byte follows
`define KCPU_OP_LDA   8'h86
`define KCPU_OP_ADDA  8'h8b
`define KCPU_OP_ANDA  8'h84
`define KCPU_OP_EORA  8'h88

// direct store, address byte follows
`define KCPU_OP_STA   8'h97

// accumulator stack ops
`define KCPU_OP_PSHA  8'h36
`define KCPU_OP_PULA  8'h32

// relative branches, signed offset byte follows
`define KCPU_OP_BRA   8'h20
`define KCPU_OP_BEQ   8'h27

`define KCPU_IRQ_VEC  8'he0    // irq entry point
`define KCPU_RESET_PC 8'h00
`define KCPU_RESET_SP 8'hc0    // stack grows down, first push lands at bf
`define KCPU_UROWS    8'd16    // microcode rows per category

`endif
